// ==== hdl/lau_pkg.sv ====
// Shared types and constants for the up/down counter and its prefix arithmetic
// Compile first and reference members with lau_pkg:: scoped names

package lau_pkg;

	// Prefix network structure selection
	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // Serial chain
		MEDIUM = 2'b01,  // Brent-Kung
		FAST   = 2'b10   // Sklansky
	} speed_e;

	// Floor of log2 for positive n
	// Returns -1 for n of zero
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

	localparam int     CNT_W     = 16;    // Counter word width
	localparam speed_e CNT_SPEED = FAST;  // Prefix structure for the counter

	// Per-cycle command, sampled every rising edge
	typedef struct packed {
		logic             en;          // Count enable
		logic             dec;         // 1 counts down
		logic             load;        // Synchronous load, wins over en
		logic [CNT_W-1:0] load_value;  // Value taken on load
	} cnt_cmd_t;

	// Registered counter outputs
	typedef struct packed {
		logic [CNT_W-1:0] count;  // Current count
		logic             wrap;   // One-cycle pulse on boundary crossing
	} cnt_status_t;

endpackage

// ==== hdl/prefix_and.sv ====
// Parallel-prefix AND network, bit i of the output is the AND of input bits 0..i
// Structure picked at elaboration by speed: Sklansky, Brent-Kung or a serial chain
// Purely combinational

`timescale 1ns/1ps

module prefix_and #(
	parameter int              width = 8,              // Word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST   // Structure select
) (
	input  logic [width-1:0] prop_in,   // Propagate in
	output logic [width-1:0] prop_out   // Prefix propagate out
);

	localparam int n = width;

	// Tree depth, ceil(log2(n)) from the floor helper
	localparam int m = (n > 1) ? lau_pkg::log2floor(n - 1) + 1 : 0;

	// Sklansky, log2 depth with high fan-out
	if (speed == lau_pkg::FAST) begin : g_fast
		logic [m:0][n-1:0] pt;  // One row per level

		assign pt[0] = prop_in;

		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar j = 0; j < n; j++) begin : g_bit
				// Upper half of each 2**l block takes the last bit of the lower half
				if ((j % (2**l)) >= 2**(l-1)) begin : g_black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][(j / 2**l) * 2**l + 2**(l-1) - 1];
				end else begin : g_white
					assign pt[l][j] = pt[l-1][j];  // Pass through
				end
			end
		end

		assign prop_out = pt[m];
	end

	// Brent-Kung, up-sweep tree then down-sweep fill-in
	if (speed == lau_pkg::MEDIUM) begin : g_medium
		localparam int last = (m > 0) ? 2*m - 1 : 0;  // Index of the final row

		logic [last:0][n-1:0] pt;

		assign pt[0] = prop_in;

		// Up-sweep, combine at the top bit of every 2**l block
		for (genvar l = 1; l <= m; l++) begin : g_up
			for (genvar j = 0; j < n; j++) begin : g_bit
				if (((j + 1) % (2**l)) == 0) begin : g_black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2**(l-1)];
				end else begin : g_white
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		// Down-sweep, fill the mid points of shrinking spans
		for (genvar l = m + 1; l <= last; l++) begin : g_down
			localparam int span = 2**(2*m - l);
			localparam int half = span / 2;

			for (genvar j = 0; j < n; j++) begin : g_bit
				if ((j >= span) && (((j + 1) % span) == half)) begin : g_black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - half];
				end else begin : g_white
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign prop_out = pt[last];
	end

	// Serial ripple chain, smallest area and n-1 gate delays
	if (speed == lau_pkg::SLOW) begin : g_slow
		logic [n-1:0] pt;

		assign pt[0] = prop_in[0];
		for (genvar j = 1; j < n; j++) begin : g_bit
			assign pt[j] = prop_in[j] & pt[j-1];
		end

		assign prop_out = pt;
	end

endmodule

// ==== hdl/inc_dec.sv ====
// Incrementer-decrementer on a parallel-prefix AND network
// result = dec ? operand - 1 : operand + 1, purely combinational

`timescale 1ns/1ps

module inc_dec #(
	parameter int              width = 8,             // Word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST  // Prefix structure
) (
	input  logic [width-1:0] operand,  // Value to step
	input  logic             dec,      // 1 subtracts one
	output logic [width-1:0] result    // Stepped value
);

	logic [width-1:0] prop;    // Bits that pass the carry or borrow
	logic [width-1:0] prefix;  // All lower bits propagate

	// Ones propagate a carry, zeros propagate a borrow
	assign prop = operand ^ {width{dec}};

	prefix_and #(
		.width (width),
		.speed (speed)
	) i_prefix_and (
		.prop_in  (prop),
		.prop_out (prefix)
	);

	// Bit 0 always flips
	// Bit i flips when every bit below it propagates
	assign result = operand ^ {prefix[width-2:0], 1'b1};

endmodule

// ==== hdl/up_down_counter.sv ====
// Registered up/down counter with synchronous load and count enable
// Next value comes from inc_dec, wrap pulses for one cycle at the word boundary
// Load beats en, en low holds the count

`timescale 1ns/1ps

module up_down_counter (
	input  logic                 clk,     // Rising-edge clock
	input  logic                 arst_n,  // Async reset, active low
	input  lau_pkg::cnt_cmd_t    cmd,     // Command for this cycle
	output lau_pkg::cnt_status_t status   // Registered count and wrap
);

	logic [lau_pkg::CNT_W-1:0] count_q;     // Count register
	logic                      wrap_q;      // Wrap pulse register
	logic [lau_pkg::CNT_W-1:0] count_step;  // Count plus or minus one
	logic                      at_bound;    // Next step crosses the boundary

	// Next value in the commanded direction
	inc_dec #(
		.width (lau_pkg::CNT_W),
		.speed (lau_pkg::CNT_SPEED)
	) i_inc_dec (
		.operand (count_q),
		.dec     (cmd.dec),
		.result  (count_step)
	);

	// All ones going up or all zeros going down
	always_comb begin
		if (cmd.dec) begin
			at_bound = ~|count_q;  // Zero to all ones
		end else begin
			at_bound = &count_q;   // All ones to zero
		end
	end

	// Load, then count step, then hold
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
			wrap_q  <= 1'b0;
		end else if (cmd.load) begin
			count_q <= cmd.load_value;
			wrap_q  <= 1'b0;          // No wrap on load
		end else if (cmd.en) begin
			count_q <= count_step;
			wrap_q  <= at_bound;      // Pulse with the wrapped value
		end else begin
			wrap_q  <= 1'b0;          // Count holds
		end
	end

	// Outputs straight from the registers
	assign status.count = count_q;
	assign status.wrap  = wrap_q;

endmodule

// ==== hdl/counter_top.sv ====
// Top level of the up/down counter
// Takes one command struct per cycle and returns the registered status struct
// One cycle of latency from command to status

`timescale 1ns/1ps

module counter_top (
	input  logic                 clk,     // Rising-edge clock
	input  logic                 arst_n,  // Async reset, active low
	input  lau_pkg::cnt_cmd_t    cmd,     // Level command, no handshake
	output lau_pkg::cnt_status_t status   // Count and wrap pulse
);

	// Command goes through unchanged
	up_down_counter i_up_down_counter (
		.clk    (clk),
		.arst_n (arst_n),
		.cmd    (cmd),
		.status (status)
	);

endmodule

// ==== verification/counter_properties.sv ====
// Concurrent checks on the counter register, bound into up_down_counter
// Covers wrap after load or idle, load latency and wrap only at the boundary

`timescale 1ns/1ps

module counter_properties (
	input logic                 clk,
	input logic                 arst_n,
	input lau_pkg::cnt_cmd_t    cmd,
	input lau_pkg::cnt_status_t status
);

	// No wrap after a load or an idle cycle
	a_no_wrap_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(cmd.load || !cmd.en) |=> !status.wrap)
		else $error("wrap high after a load or idle cycle");

	// Loaded value shows up one cycle later
	a_load_value: assert property (@(posedge clk) disable iff (!arst_n)
		cmd.load |=> (status.count == $past(cmd.load_value)))
		else $error("count differs from loaded value");

	// Wrap only with the count at zero or all ones
	a_wrap_bound: assert property (@(posedge clk) disable iff (!arst_n)
		status.wrap |-> ((status.count == '0) || (status.count == '1)))
		else $error("wrap high away from the word boundary");

endmodule

bind up_down_counter counter_properties i_counter_properties (
	.clk    (clk),
	.arst_n (arst_n),
	.cmd    (cmd),
	.status (status)
);

// ==== verification/counter_tb.sv ====
// Directed testbench for counter_top that checks count and wrap every cycle
// A model of the command rules runs beside the DUT and predicts status
// Commands change on the falling edge and status is sampled there too

`timescale 1ns/1ps

module counter_tb;

	localparam int W = lau_pkg::CNT_W;

	logic                 clk;
	logic                 arst_n;
	lau_pkg::cnt_cmd_t    cmd;
	lau_pkg::cnt_status_t status;

	logic [W-1:0] model_count;  // Predicted count
	logic         model_wrap;   // Predicted wrap pulse

	counter_top DUT (
		.clk    (clk),
		.arst_n (arst_n),
		.cmd    (cmd),
		.status (status)
	);

	// 10 ns clock
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset held 5 cycles and released on a falling edge
	initial begin
		arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	end

	// Model follows load, then step, then hold with one cycle of latency
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			model_count <= '0;
			model_wrap  <= 1'b0;
		end else if (cmd.load) begin
			model_count <= cmd.load_value;
			model_wrap  <= 1'b0;
		end else if (cmd.en) begin
			if (cmd.dec) begin
				model_count <= model_count - 1'b1;
				model_wrap  <= (model_count == {W{1'b0}});  // 0 down to all ones
			end else begin
				model_count <= model_count + 1'b1;
				model_wrap  <= (model_count == {W{1'b1}});  // All ones up to 0
			end
		end else begin
			model_wrap <= 1'b0;
		end
	end

	// Global limit on run time
	initial begin
		#20000;
		$display("Run did not finish within 20000 ns");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s", what);
		stop_on_error();
	endtask

	function automatic lau_pkg::cnt_status_t make_status(input logic [W-1:0] count,
			input logic wrap);
		lau_pkg::cnt_status_t s;
		s.count = count;
		s.wrap  = wrap;
		return s;
	endfunction

	task automatic check_count(input logic [W-1:0] actual, input logic [W-1:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s count %h expected %h",
				$time, what, actual, expected);
			stop_on_error();
		end
	endtask

	task automatic check_status(input lau_pkg::cnt_status_t actual,
			input lau_pkg::cnt_status_t expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s count %h wrap %b expected count %h wrap %b",
				$time, what, actual.count, actual.wrap, expected.count, expected.wrap);
			stop_on_error();
		end
	endtask

	// Drive one command at this falling edge and compare at the next
	task automatic run_cycle(input logic en, input logic dec, input logic load,
			input logic [W-1:0] value);
		cmd.en         = en;
		cmd.dec        = dec;
		cmd.load       = load;
		cmd.load_value = value;
		@(negedge clk);
		check_status(status, make_status(model_count, model_wrap), "model compare");
	endtask

	task automatic test_reset();
		int waited;
		waited = 0;
		@(negedge clk);
		check_status(status, make_status('0, 1'b0), "during reset");
		while (arst_n !== 1'b1) begin  // First clock after release
			@(posedge clk);
			waited++;
			if (waited > 20) timeout_fail("reset release");
		end
		@(negedge clk);  // Back on the drive edge
		check_status(status, make_status('0, 1'b0), "after reset");
	endtask

	task automatic test_increment(input logic [W-1:0] start, input int steps);
		logic [W-1:0] exp_count;
		logic         exp_wrap;
		run_cycle(1'b0, 1'b0, 1'b1, start);
		check_status(status, make_status(start, 1'b0), "increment load");
		exp_count = start;
		for (int k = 0; k < steps; k++) begin
			exp_wrap  = (exp_count == {W{1'b1}});
			exp_count = exp_count + 1'b1;
			run_cycle(1'b1, 1'b0, 1'b0, '0);
			check_status(status, make_status(exp_count, exp_wrap), "increment step");
		end
	endtask

	task automatic test_decrement(input logic [W-1:0] start, input int steps);
		logic [W-1:0] exp_count;
		logic         exp_wrap;
		run_cycle(1'b0, 1'b0, 1'b1, start);
		check_status(status, make_status(start, 1'b0), "decrement load");
		exp_count = start;
		for (int k = 0; k < steps; k++) begin
			exp_wrap  = (exp_count == {W{1'b0}});
			exp_count = exp_count - 1'b1;
			run_cycle(1'b1, 1'b1, 1'b0, '0);
			check_status(status, make_status(exp_count, exp_wrap), "decrement step");
		end
	endtask

	task automatic test_priority_hold();
		run_cycle(1'b0, 1'b0, 1'b1, 16'hFFFF);
		run_cycle(1'b1, 1'b0, 1'b1, 16'h1234);  // Step would wrap but load wins
		check_status(status, make_status(16'h1234, 1'b0), "load over en");
		run_cycle(1'b0, 1'b0, 1'b1, 16'hFFFF);
		run_cycle(1'b1, 1'b0, 1'b0, '0);  // Wrap pulse right before the hold
		check_status(status, make_status(16'h0000, 1'b1), "wrap before hold");
		for (int k = 0; k < 5; k++) begin
			run_cycle(1'b0, k[0], 1'b0, 16'hBEEF);  // Value ignored
			check_status(status, make_status(16'h0000, 1'b0), "hold");
		end
	endtask

	task automatic test_carry_chains();
		logic [W-1:0] vals [6];
		vals = '{16'h7FFF, 16'h8000, 16'h00FF, 16'h0100, 16'hFFFF, 16'h0000};
		foreach (vals[i]) begin
			run_cycle(1'b0, 1'b0, 1'b1, vals[i]);
			run_cycle(1'b1, 1'b0, 1'b0, '0);
			check_count(status.count, vals[i] + 16'h0001, "carry increment");
			run_cycle(1'b0, 1'b0, 1'b1, vals[i]);
			run_cycle(1'b1, 1'b1, 1'b0, '0);
			check_count(status.count, vals[i] - 16'h0001, "borrow decrement");
		end
	endtask

	task automatic test_random();
		logic         en;
		logic         dec;
		logic         load;
		logic [W-1:0] value;
		for (int k = 0; k < 200; k++) begin
			en    = $urandom % 2;
			dec   = $urandom % 2;
			load  = ($urandom % 10) == 0;  // About one load in ten
			value = $urandom;
			run_cycle(en, dec, load, value);
		end
	endtask

	initial begin
		cmd = '0;
		void'($urandom(32'h11b5f8e0));
		test_reset();
		test_increment(16'h00FC, 8);  // Byte carry without wrap
		test_increment(16'hFFFC, 8);  // Through the top
		test_decrement(16'h0003, 6);  // Through zero
		test_priority_hold();
		test_carry_chains();
		test_random();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/lau_pkg.sv
hdl/prefix_and.sv
hdl/inc_dec.sv
hdl/up_down_counter.sv
hdl/counter_top.sv
verification/counter_properties.sv
verification/counter_tb.sv
